/* filelist.f */
+incdir+hw
hw/uart_tx_pkg.sv
hw/press_edge_detect.sv
hw/baud_tick_gen.sv
hw/uart_byte_tx.sv
hw/word_frame_sequencer.sv
hw/fp32_uart_top.sv
tb/fp32_uart_props.sv
tb/fp32_uart_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := fp32_uart_tb
FILELIST  := filelist.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)
PASS_MSG  := No errors

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* tb/fp32_uart_tb.sv */
`default_nettype none

`include "uart_tx_defines.svh"

module fp32_uart_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_PERIOD   = 40;
    localparam int WORD_BYTES   = `UART_BYTES_PER_WORD;
    localparam int WORD_W       = WORD_BYTES * `UART_DATA_BITS;
    localparam int NUM_PRESSES  = 6; // accepted presses over the whole run
    // 11 bit-times per byte covers lead, start, data and stop
    localparam int RUN_NS       = NUM_PRESSES * WORD_BYTES * 11 * CLKS_PER_BIT * CLK_PERIOD;
    localparam int LIMIT_NS     = 2 * RUN_NS + 1000 * CLK_PERIOD;

    logic              CLK_I;
    logic              RSTL_I;
    logic              tx_valid_n;
    logic [WORD_W-1:0] tx_word;
    logic              tx;
    logic              busy;

    integer            seed       = 32'hcb268400;
    logic [7:0]        exp_q[$];
    int                sent_count = 0;
    int                rx_count   = 0;
    int                high_clks  = 0; // clocks tx has been high in a row

    fp32_uart_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) fp32_uart_top_i (
        .CLK_I      (CLK_I),
        .RSTL_I     (RSTL_I),
        .tx_valid_n (tx_valid_n),
        .tx_word    (tx_word),
        .tx         (tx),
        .busy       (busy)
    );

    initial begin
        CLK_I = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK_I = ~CLK_I;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("FAILED %s expected %h got %h", name, expected, actual));
    endtask

    task automatic queue_word(input logic [WORD_W-1:0] word);
        for (int i = 0; i < WORD_BYTES; i++) begin
            exp_q.push_back(word[i*8 +: 8]); // lsb byte first
        end
        sent_count += WORD_BYTES;
    endtask

    task automatic wait_busy(input logic level);
        @(negedge CLK_I);
        while (busy !== level) begin
            @(negedge CLK_I);
        end
    endtask

    task automatic press_button(input int hold_cycles);
        @(posedge CLK_I);
        tx_valid_n <= 1'b0;
        repeat (hold_cycles) @(posedge CLK_I);
        tx_valid_n <= 1'b1;
    endtask

    task automatic send_word(input logic [WORD_W-1:0] word);
        @(posedge CLK_I);
        tx_word <= word;
        queue_word(word);
        press_button(2);
        wait_busy(1'b1);
        wait_busy(1'b0);
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge CLK_I);
            assert (tx === 1'b1) else report_mismatch("tx", 32'h1, 32'(tx));
            assert (busy === 1'b0) else report_mismatch("busy", 32'h0, 32'(busy));
        end
    endtask

    always @(negedge CLK_I) begin
        if (tx === 1'b1) begin
            high_clks <= high_clks + 1;
        end else begin
            high_clks <= 0;
        end
    end

    // serial line decoder sampling mid-bit on the falling clock
    initial begin : line_decoder
        logic [7:0] rx_byte;
        wait (RSTL_I === 1'b1);
        forever begin
            @(negedge tx);
            // stop bit plus at least one idle bit-time
            assert (high_clks >= 2 * CLKS_PER_BIT)
                else abort_run("start bit came too soon after the previous stop bit");
            repeat (CLKS_PER_BIT / 2) @(negedge CLK_I);
            assert (tx === 1'b0) else report_mismatch("tx", 32'h0, 32'(tx));
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge CLK_I);
                rx_byte[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge CLK_I);
            assert (tx === 1'b1) else report_mismatch("tx", 32'h1, 32'(tx));
            if (exp_q.size() == 0) begin
                abort_run("a frame arrived while no byte was expected");
            end else begin
                assert (rx_byte === exp_q[0])
                    else report_mismatch("rx_byte", 32'(exp_q[0]), 32'(rx_byte));
                void'(exp_q.pop_front());
                rx_count++;
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        abort_run("timeout, the transfers did not finish in time");
    end

    initial begin : stimulus
        logic [WORD_W-1:0] word;
        RSTL_I     = 1'b0;
        tx_valid_n = 1'b1;
        tx_word    = '0;
        repeat (3) @(posedge CLK_I);
        RSTL_I <= 1'b1;
        check_idle(16);

        // back-to-back words
        for (int n = 0; n < 4; n++) begin
            word = $random(seed);
            send_word(word);
        end

        // button held well past the end of the transfer
        word = $random(seed);
        @(posedge CLK_I);
        tx_word <= word;
        queue_word(word);
        @(posedge CLK_I);
        tx_valid_n <= 1'b0;
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_idle(4 * CLKS_PER_BIT);
        @(posedge CLK_I);
        tx_valid_n <= 1'b1;
        check_idle(8);

        // presses and a new word mid-transfer
        word = $random(seed);
        @(posedge CLK_I);
        tx_word <= word;
        queue_word(word);
        press_button(2);
        wait_busy(1'b1);
        repeat (3 * CLKS_PER_BIT) @(posedge CLK_I);
        tx_word <= $random(seed);
        press_button(2);
        repeat (20 * CLKS_PER_BIT) @(posedge CLK_I);
        press_button(2);
        wait_busy(1'b0);
        check_idle(3 * CLKS_PER_BIT);

        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d bytes still pending, %0d of %0d bytes received",
                                exp_q.size(), rx_count, sent_count));
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/fp32_uart_props.sv */
`default_nettype none

`include "uart_tx_defines.svh"

module fp32_uart_props
    import uart_tx_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input logic        CLK_I,
    input logic        RSTL_I,
    input logic        tx,
    input logic        busy,
    input logic        frame_req,
    input logic        frame_ack,
    input uart_frame_t frame
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MIN_HOLD_I = CLKS_PER_BIT - 1;
    localparam logic [`UART_CNT_W-1:0] MIN_HOLD = MIN_HOLD_I[`UART_CNT_W-1:0];

    logic                   tx_q;
    logic [`UART_CNT_W-1:0] run_len; // clocks since tx last changed, minus one

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            tx_q    <= 1'b1;
            run_len <= '1;   // first edge after reset is free
        end else begin
            tx_q <= tx;
            if (tx != tx_q) begin
                run_len <= '0;
            end else if (run_len != '1) begin
                run_len <= run_len + 1'b1; // saturates
            end
        end
    end

    idle_line_high: assert property (@(posedge CLK_I) disable iff (!RSTL_I)
        !busy |-> tx)
        else $error("tx is low while busy is low");

    req_held: assert property (@(posedge CLK_I) disable iff (!RSTL_I)
        frame_req && !frame_ack |=> frame_req)
        else $error("frame_req dropped before frame_ack");

    // payload must not move under a pending request
    frame_stable: assert property (@(posedge CLK_I) disable iff (!RSTL_I)
        frame_req && !frame_ack |=> $stable(frame))
        else $error("frame changed while frame_req waits for frame_ack");

    ack_held: assert property (@(posedge CLK_I) disable iff (!RSTL_I)
        frame_ack && frame_req |=> frame_ack)
        else $error("frame_ack dropped before frame_req fell");

    no_req_during_ack: assert property (@(posedge CLK_I) disable iff (!RSTL_I)
        !frame_req && frame_ack |=> !frame_req)
        else $error("frame_req rose again while frame_ack was high");

    min_bit_time: assert property (@(posedge CLK_I) disable iff (!RSTL_I)
        tx != tx_q |-> run_len >= MIN_HOLD)
        else $error("tx level held for less than one bit-time");

endmodule

bind fp32_uart_top fp32_uart_props #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
) fp32_uart_props_i (
    .CLK_I     (CLK_I),
    .RSTL_I    (RSTL_I),
    .tx        (tx),
    .busy      (busy),
    .frame_req (frame_req),
    .frame_ack (frame_ack),
    .frame     (frame)
);

`default_nettype wire

/* hw/fp32_uart_top.sv */
`default_nettype none

`include "uart_tx_defines.svh"

module fp32_uart_top
    import uart_tx_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic                                            CLK_I,
    input  logic                                            RSTL_I,
    input  logic                                            tx_valid_n,
    input  logic [`UART_BYTES_PER_WORD*`UART_DATA_BITS-1:0] tx_word,
    output logic                                            tx,
    output logic                                            busy
);

    logic        press;
    logic        frame_req;
    logic        frame_ack;
    uart_frame_t frame;

    press_edge_detect press_edge_detect_i (
        .CLK_I      (CLK_I),
        .RSTL_I     (RSTL_I),
        .tx_valid_n (tx_valid_n),
        .press      (press)
    );

    word_frame_sequencer word_frame_sequencer_i (
        .CLK_I     (CLK_I),
        .RSTL_I    (RSTL_I),
        .press     (press),
        .tx_word   (tx_word),
        .frame_req (frame_req),
        .frame     (frame),
        .frame_ack (frame_ack),
        .busy      (busy)
    );

    // divider lives inside the serializer
    uart_byte_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_byte_tx_i (
        .CLK_I     (CLK_I),
        .RSTL_I    (RSTL_I),
        .frame_req (frame_req),
        .frame     (frame),
        .frame_ack (frame_ack),
        .tx        (tx)
    );

endmodule

`default_nettype wire

/* hw/word_frame_sequencer.sv */
`default_nettype none

`include "uart_tx_defines.svh"

module word_frame_sequencer
    import uart_tx_pkg::*;
(
    input  logic                                            CLK_I,
    input  logic                                            RSTL_I,
    input  logic                                            press,
    input  logic [`UART_BYTES_PER_WORD*`UART_DATA_BITS-1:0] tx_word,
    output logic                                            frame_req,
    output uart_frame_t                                     frame,
    input  logic                                            frame_ack,
    output logic                                            busy
);

    localparam int WORD_W     = `UART_BYTES_PER_WORD * `UART_DATA_BITS;
    localparam int IDX_W      = $clog2(`UART_BYTES_PER_WORD);
    localparam int LAST_IDX_I = `UART_BYTES_PER_WORD - 1;
    localparam logic [IDX_W-1:0] LAST_IDX = LAST_IDX_I[IDX_W-1:0];

    logic [WORD_W-1:0] word_q;
    logic [IDX_W-1:0]  byte_idx;
    logic              accept;

    // presses during a transfer are simply dropped
    assign accept = press && !busy;

    always_ff @(posedge CLK_I) begin
        if (accept) begin
            word_q <= tx_word;
        end
    end

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            busy      <= 1'b0;
            frame_req <= 1'b0;
            byte_idx  <= '0;
        end else if (!busy) begin
            if (accept) begin
                busy      <= 1'b1;
                frame_req <= 1'b1; // byte 0 goes out right away
                byte_idx  <= '0;
            end
        end else if (frame_req && frame_ack) begin
            frame_req <= 1'b0;
        end else if (!frame_req && !frame_ack) begin
            // ack is back low, handshake for this byte is closed
            if (byte_idx == LAST_IDX) begin
                busy <= 1'b0;
            end else begin
                byte_idx  <= byte_idx + 1'b1;
                frame_req <= 1'b1;
            end
        end
    end

    // index only moves with req low, so frame is stable under req
    assign frame.lead_idle = (byte_idx != '0);
    assign frame.data      = word_q[byte_idx*`UART_DATA_BITS +: `UART_DATA_BITS];

endmodule

`default_nettype wire

/* hw/uart_byte_tx.sv */
`default_nettype none

`include "uart_tx_defines.svh"

module uart_byte_tx
    import uart_tx_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic        CLK_I,
    input  logic        RSTL_I,
    input  logic        frame_req,
    input  uart_frame_t frame,
    output logic        frame_ack,
    output logic        tx
);

    localparam int BIT_W      = $clog2(`UART_DATA_BITS);
    localparam int LAST_BIT_I = `UART_DATA_BITS - 1;
    localparam logic [BIT_W-1:0] LAST_BIT = LAST_BIT_I[BIT_W-1:0];

    tx_state_t                  state;
    logic [BIT_W-1:0]           bit_cnt;
    logic [`UART_DATA_BITS-1:0] shift_q;
    logic                       bit_en;
    logic                       bit_tick;

    baud_tick_gen #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) baud_tick_gen_i (
        .CLK_I    (CLK_I),
        .RSTL_I   (RSTL_I),
        .bit_en   (bit_en),
        .bit_tick (bit_tick)
    );

    // shifter holds payload only
    always_ff @(posedge CLK_I) begin
        if (state == TX_IDLE && frame_req) begin
            shift_q <= frame.data;
        end else if ((state == TX_START || state == TX_DATA) && bit_tick) begin
            shift_q <= {1'b0, shift_q[`UART_DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            state     <= TX_IDLE;
            bit_cnt   <= '0;
            bit_en    <= 1'b0;
            frame_ack <= 1'b0;
            tx        <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (frame_req) begin
                        bit_en <= 1'b1;
                        if (frame.lead_idle) begin
                            state <= TX_LEAD; // line stays high one more bit
                        end else begin
                            state <= TX_START;
                            tx    <= 1'b0;
                        end
                    end
                end
                TX_LEAD: begin
                    if (bit_tick) begin
                        state <= TX_START;
                        tx    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        tx      <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_tick) begin
                        state     <= TX_DONE;
                        bit_en    <= 1'b0;
                        frame_ack <= 1'b1;
                    end
                end
                TX_DONE: begin
                    if (!frame_req) begin
                        state     <= TX_IDLE;
                        frame_ack <= 1'b0;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/baud_tick_gen.sv */
`default_nettype none

`include "uart_tx_defines.svh"

module baud_tick_gen #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic CLK_I,
    input  logic RSTL_I,
    input  logic bit_en,
    output logic bit_tick
);

    localparam int LAST_CNT_I = CLKS_PER_BIT - 1;
    localparam logic [`UART_CNT_W-1:0] LAST_CNT = LAST_CNT_I[`UART_CNT_W-1:0];

    logic [`UART_CNT_W-1:0] cnt;

    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            cnt <= '0;
        end else if (!bit_en) begin
            cnt <= '0; // parked until the serializer needs it
        end else if (cnt == LAST_CNT) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // last clock of the current bit-time
    assign bit_tick = bit_en && (cnt == LAST_CNT);

endmodule

`default_nettype wire

/* hw/press_edge_detect.sv */
`default_nettype none

module press_edge_detect (
    input  logic CLK_I,
    input  logic RSTL_I,
    input  logic tx_valid_n,   // button, low when pressed
    output logic press
);

    logic sync1_n;
    logic sync2_n;
    logic pressed;
    logic pressed_q;

    assign pressed = ~sync2_n;

    // two-flop sync, then one history flop for the edge
    always_ff @(posedge CLK_I or negedge RSTL_I) begin
        if (!RSTL_I) begin
            sync1_n   <= 1'b1; // released
            sync2_n   <= 1'b1;
            pressed_q <= 1'b0;
        end else begin
            sync1_n   <= tx_valid_n;
            sync2_n   <= sync1_n;
            pressed_q <= pressed;
        end
    end

    // held button gives a single pulse
    assign press = pressed & ~pressed_q;

endmodule

`default_nettype wire

/* hw/uart_tx_pkg.sv */
`default_nettype none

`include "uart_tx_defines.svh"

package uart_tx_pkg;

    // one byte plus its framing option
    typedef struct packed {
        logic                         lead_idle; // one idle bit-time before start
        logic [`UART_DATA_BITS-1:0]   data;
    } uart_frame_t;

    // serializer phases
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_LEAD,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_DONE   // waiting for req to drop
    } tx_state_t;

endpackage

`default_nettype wire

/* hw/uart_tx_defines.svh */
`ifndef UART_TX_DEFINES_SVH
`define UART_TX_DEFINES_SVH

// board clock
`define UART_CLK_FREQ_HZ 50_000_000

// serial line rate
`define UART_BAUD_RATE 115_200

// rounded divide, 434 at 50 MHz / 115200
`define UART_CLKS_PER_BIT \
    ((`UART_CLK_FREQ_HZ + (`UART_BAUD_RATE / 2)) / `UART_BAUD_RATE)

// 8N1 framing
`define UART_DATA_BITS 8

// lsb byte goes out first
`define UART_BYTES_PER_WORD 4

// wide enough for clks per bit at any sane baud
`define UART_CNT_W 16

`endif
